/* ex_params.svh */
// Execute stage parameters
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

// data word, RV32
`define EX_XLEN 32
// reorder buffer tag
`define EX_TAG_W 5
// shift amount, low bits of operand b
`define EX_SHAMT_W 5

//////////////////////////////
// lane count
//////////////////////////////

// integer lanes, drained lowest index first
`define EX_NUM_LANES 2

`endif

/* ex_pkg.sv */
// Execute stage types
`include "ex_params.svh"

package ex_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // data word
    typedef logic [`EX_XLEN-1:0] xlen_t;
    // reorder buffer tag
    typedef logic [`EX_TAG_W-1:0] rob_tag_t;
    // raw instruction word, always 32 bits in RV32
    typedef logic [31:0] inst_t;
    // one bit per integer lane
    typedef logic [`EX_NUM_LANES-1:0] lane_vec_t;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // alu function, ten RV32I ops
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5,
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_e;

    // operand a source
    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_npc  = 2'd1,
        opa_pc   = 2'd2,
        opa_zero = 2'd3
    } opa_sel_e;

    // operand b source, register or one of the immediates
    typedef enum logic [2:0] {
        opb_rs2   = 3'd0,
        opb_i_imm = 3'd1,
        opb_s_imm = 3'd2,
        opb_b_imm = 3'd3,
        opb_u_imm = 3'd4,
        opb_j_imm = 3'd5
    } opb_sel_e;

endpackage

/* alu.sv */
// Integer ALU
`include "ex_params.svh"

module alu (
    input  ex_pkg::xlen_t     opa,
    input  ex_pkg::xlen_t     opb,
    input  ex_pkg::alu_func_e func,
    output ex_pkg::xlen_t     result
);
    import ex_pkg::*;

    // signed views for slt and sra
    logic signed [`EX_XLEN-1:0] opa_s;
    logic signed [`EX_XLEN-1:0] opb_s;
    // shift amount from low bits of b
    logic [`EX_SHAMT_W-1:0] shamt;
    // compare results, widened below
    logic lt_signed;
    logic lt_unsigned;

    assign opa_s = opa;
    assign opb_s = opb;
    assign shamt = opb[`EX_SHAMT_W-1:0];

    assign lt_signed   = opa_s < opb_s;
    assign lt_unsigned = opa < opb;

    //////////////////////////////
    // function select
    //////////////////////////////

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            // zero-extended 0 or 1
            alu_slt:  result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            alu_sll:  result = opa << shamt;
            alu_srl:  result = opa >> shamt;
            // sign fills from the top
            alu_sra:  result = opa_s >>> shamt;
            // six codes unused
            default:  result = '0;
        endcase
    end

endmodule

/* branch_cond.sv */
// Conditional branch compare
`include "ex_params.svh"

module branch_cond (
    input  logic [2:0]    funct3,
    input  ex_pkg::xlen_t rs1,
    input  ex_pkg::xlen_t rs2,
    output logic          take
);
    import ex_pkg::*;

    // signed copies for blt and bge
    logic signed [$bits(xlen_t)-1:0] rs1_s;
    logic signed [$bits(xlen_t)-1:0] rs2_s;

    assign rs1_s = rs1;
    assign rs2_s = rs2;

    //////////////////////////////
    // funct3 decode
    //////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  take = rs1 == rs2;      // beq
            3'b001:  take = rs1 != rs2;      // bne
            3'b100:  take = rs1_s < rs2_s;   // blt
            3'b101:  take = rs1_s >= rs2_s;  // bge
            3'b110:  take = rs1 < rs2;       // bltu
            3'b111:  take = rs1 >= rs2;      // bgeu
            // 010 and 011 are not branches
            default: take = 1'b0;
        endcase
    end

endmodule

/* ex_lane.sv */
// Integer execute lane
`include "ex_params.svh"

module ex_lane (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ex_pkg::alu_func_e alu_func,
    input  ex_pkg::opa_sel_e  opa_select,
    input  ex_pkg::opb_sel_e  opb_select,
    input  ex_pkg::xlen_t     rs1_val,
    input  ex_pkg::xlen_t     rs2_val,
    input  ex_pkg::xlen_t     pc,
    input  ex_pkg::xlen_t     npc,
    input  ex_pkg::inst_t     inst,
    input  ex_pkg::rob_tag_t  rob_tag,
    input  logic              cond_branch,
    input  logic              uncond_branch,
    input  logic              mem_op,
    input  logic              grant,
    output logic              cand_valid,
    output logic              cand_is_mem,
    output ex_pkg::rob_tag_t  cand_tag,
    output ex_pkg::xlen_t     cand_value,
    output logic              cand_take,
    output logic              busy
);
    import ex_pkg::*;

    // sign-extended immediates
    xlen_t i_imm, s_imm, b_imm, u_imm, j_imm;
    // alu inputs and output
    xlen_t opa, opb, alu_result;
    // fresh result of this cycle's issue
    logic  cond_true;
    logic  fresh_take;
    xlen_t fresh_value;
    // one-entry hold
    logic     hold_valid;
    logic     hold_is_mem;
    logic     hold_take;
    rob_tag_t hold_tag;
    xlen_t    hold_value;

    //////////////////////////////
    // operand selection
    //////////////////////////////

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opa_select)
            opa_rs1:  opa = rs1_val;
            opa_npc:  opa = npc;
            opa_pc:   opa = pc;
            default:  opa = '0;
        endcase
    end

    always_comb begin
        case (opb_select)
            opb_rs2:   opb = rs2_val;
            opb_i_imm: opb = i_imm;
            opb_s_imm: opb = s_imm;
            opb_b_imm: opb = b_imm;
            opb_u_imm: opb = u_imm;
            opb_j_imm: opb = j_imm;
            default:   opb = '0;
        endcase
    end

    //////////////////////////////
    // compute
    //////////////////////////////

    alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (alu_func),
        .result (alu_result)
    );

    // compare always on register values, funct3 straight from inst
    branch_cond u_branch_cond (
        .funct3 (inst[14:12]),
        .rs1    (rs1_val),
        .rs2    (rs2_val),
        .take   (cond_true)
    );

    assign fresh_take = uncond_branch | (cond_branch & cond_true);
    // untaken conditional falls through to npc
    assign fresh_value = (cond_branch && !cond_true) ? npc : alu_result;

    //////////////////////////////
    // hold register
    //////////////////////////////

    // occupied while the candidate waits for a grant
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= cand_valid & ~grant;
        end
    end

    // capture only a fresh item that lost arbitration
    always_ff @(posedge clk) begin
        if (issue_valid && !grant) begin
            hold_is_mem <= mem_op;
            hold_take   <= fresh_take;
            hold_tag    <= rob_tag;
            hold_value  <= fresh_value;
        end
    end

    // held copy wins over the fresh path
    assign cand_valid  = hold_valid | issue_valid;
    assign cand_is_mem = hold_valid ? hold_is_mem : mem_op;
    assign cand_take   = hold_valid ? hold_take : fresh_take;
    assign cand_tag    = hold_valid ? hold_tag : rob_tag;
    assign cand_value  = hold_valid ? hold_value : fresh_value;
    assign busy        = hold_valid;

    //////////////////////////////
    // checks
    //////////////////////////////

    // upstream must respect lane_busy
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !busy);

    // a waiting item does not change under the arbiter
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        hold_valid && !grant |=> hold_valid
            && $stable({hold_is_mem, hold_take, hold_tag, hold_value}));

endmodule

/* completion_arbiter.sv */
// Completion and address bus arbiter
`include "ex_params.svh"

module completion_arbiter (
    input  logic                                   clk,
    input  logic                                   rst,
    input  ex_pkg::lane_vec_t                      cand_valid,
    input  ex_pkg::lane_vec_t                      cand_is_mem,
    input  ex_pkg::rob_tag_t [`EX_NUM_LANES-1:0]   cand_tag,
    input  ex_pkg::xlen_t [`EX_NUM_LANES-1:0]      cand_value,
    input  ex_pkg::lane_vec_t                      cand_take,
    input  logic                                   cdb_busy,
    output ex_pkg::lane_vec_t                      grant,
    output logic                                   cdb_valid,
    output ex_pkg::rob_tag_t                       cdb_tag,
    output ex_pkg::xlen_t                          cdb_value,
    output logic                                   cdb_take_branch,
    output logic                                   addr_valid,
    output ex_pkg::rob_tag_t                       addr_tag,
    output ex_pkg::xlen_t                          addr
);
    import ex_pkg::*;

    // requests and one-hot grants per bus
    lane_vec_t cdb_req, addr_req;
    lane_vec_t cdb_gnt, addr_gnt;
    // winner payload, ahead of the output flops
    rob_tag_t  cdb_tag_d, addr_tag_d;
    xlen_t     cdb_value_d, addr_d;
    logic      cdb_take_d;

    // lowest set bit, lane 0 first
    function automatic lane_vec_t pick_lowest(input lane_vec_t req);
        return req & (~req + 1'b1);
    endfunction

    //////////////////////////////
    // pickers
    //////////////////////////////

    // cdb stalls on busy, address bus never does
    assign cdb_req  = cand_valid & ~cand_is_mem & {`EX_NUM_LANES{~cdb_busy}};
    assign addr_req = cand_valid & cand_is_mem;

    assign cdb_gnt  = pick_lowest(cdb_req);
    assign addr_gnt = pick_lowest(addr_req);
    assign grant    = cdb_gnt | addr_gnt;

    // one-hot mux of the winners
    always_comb begin
        cdb_tag_d   = '0;
        cdb_value_d = '0;
        cdb_take_d  = 1'b0;
        addr_tag_d  = '0;
        addr_d      = '0;
        for (int i = 0; i < `EX_NUM_LANES; i++) begin
            if (cdb_gnt[i]) begin
                cdb_tag_d   = cand_tag[i];
                cdb_value_d = cand_value[i];
                cdb_take_d  = cand_take[i];
            end
            if (addr_gnt[i]) begin
                addr_tag_d = cand_tag[i];
                addr_d     = cand_value[i];
            end
        end
    end

    //////////////////////////////
    // output registers
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_valid  <= 1'b0;
            addr_valid <= 1'b0;
        end else begin
            cdb_valid  <= |cdb_gnt;
            addr_valid <= |addr_gnt;
        end
    end

    // payload follows the grant, held otherwise
    always_ff @(posedge clk) begin
        if (|cdb_gnt) begin
            cdb_tag         <= cdb_tag_d;
            cdb_value       <= cdb_value_d;
            cdb_take_branch <= cdb_take_d;
        end
        if (|addr_gnt) begin
            addr_tag <= addr_tag_d;
            addr     <= addr_d;
        end
    end

    // each lane goes to one bus at most
    a_one_bus: assert property (@(posedge clk) disable iff (rst)
        (cdb_gnt & addr_gnt) == '0);

endmodule

/* stage_ex.sv */
// Execute stage top level
`include "ex_params.svh"

module stage_ex (
    input  logic                                     clk,
    input  logic                                     rst,
    // issue, one entry per lane
    input  ex_pkg::lane_vec_t                        issue_valid,
    input  ex_pkg::alu_func_e [`EX_NUM_LANES-1:0]    alu_func,
    input  ex_pkg::opa_sel_e [`EX_NUM_LANES-1:0]     opa_select,
    input  ex_pkg::opb_sel_e [`EX_NUM_LANES-1:0]     opb_select,
    input  ex_pkg::xlen_t [`EX_NUM_LANES-1:0]        rs1_val,
    input  ex_pkg::xlen_t [`EX_NUM_LANES-1:0]        rs2_val,
    input  ex_pkg::xlen_t [`EX_NUM_LANES-1:0]        pc,
    input  ex_pkg::xlen_t [`EX_NUM_LANES-1:0]        npc,
    input  ex_pkg::inst_t [`EX_NUM_LANES-1:0]        inst,
    input  ex_pkg::rob_tag_t [`EX_NUM_LANES-1:0]     rob_tag,
    input  ex_pkg::lane_vec_t                        cond_branch,
    input  ex_pkg::lane_vec_t                        uncond_branch,
    input  ex_pkg::lane_vec_t                        mem_op,
    // reorder buffer side stall
    input  logic                                     cdb_busy,
    // completion bus
    output logic                                     cdb_valid,
    output ex_pkg::rob_tag_t                         cdb_tag,
    output ex_pkg::xlen_t                            cdb_value,
    output logic                                     cdb_take_branch,
    // address bus for loads and stores
    output logic                                     addr_valid,
    output ex_pkg::rob_tag_t                         addr_tag,
    output ex_pkg::xlen_t                            addr,
    output ex_pkg::lane_vec_t                        lane_busy
);
    import ex_pkg::*;

    // lane to arbiter
    lane_vec_t                      cand_valid, cand_is_mem, cand_take, grant;
    rob_tag_t [`EX_NUM_LANES-1:0]   cand_tag;
    xlen_t [`EX_NUM_LANES-1:0]      cand_value;

    //////////////////////////////
    // lanes
    //////////////////////////////

    for (genvar i = 0; i < `EX_NUM_LANES; i++) begin : g_lane
        ex_lane u_lane (
            .clk           (clk),
            .rst           (rst),
            .issue_valid   (issue_valid[i]),
            .alu_func      (alu_func[i]),
            .opa_select    (opa_select[i]),
            .opb_select    (opb_select[i]),
            .rs1_val       (rs1_val[i]),
            .rs2_val       (rs2_val[i]),
            .pc            (pc[i]),
            .npc           (npc[i]),
            .inst          (inst[i]),
            .rob_tag       (rob_tag[i]),
            .cond_branch   (cond_branch[i]),
            .uncond_branch (uncond_branch[i]),
            .mem_op        (mem_op[i]),
            .grant         (grant[i]),
            .cand_valid    (cand_valid[i]),
            .cand_is_mem   (cand_is_mem[i]),
            .cand_tag      (cand_tag[i]),
            .cand_value    (cand_value[i]),
            .cand_take     (cand_take[i]),
            .busy          (lane_busy[i])
        );
    end

    //////////////////////////////
    // drain
    //////////////////////////////

    completion_arbiter u_arbiter (
        .clk             (clk),
        .rst             (rst),
        .cand_valid      (cand_valid),
        .cand_is_mem     (cand_is_mem),
        .cand_tag        (cand_tag),
        .cand_value      (cand_value),
        .cand_take       (cand_take),
        .cdb_busy        (cdb_busy),
        .grant           (grant),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_take_branch (cdb_take_branch),
        .addr_valid      (addr_valid),
        .addr_tag        (addr_tag),
        .addr            (addr)
    );

endmodule

/* tb_stage_ex.sv */
// Execute stage testbench
`include "ex_params.svh"

module tb_stage_ex;
    timeunit 1ns;
    timeprecision 100ps;
    import ex_pkg::*;

    localparam int MAX_LINES = 64;
    // back-pressure starts at this data line
    localparam int BUSY_FROM = 26;

    logic clk;
    logic rst;
    lane_vec_t                          issue_valid;
    alu_func_e [`EX_NUM_LANES-1:0]      alu_func;
    opa_sel_e [`EX_NUM_LANES-1:0]       opa_select;
    opb_sel_e [`EX_NUM_LANES-1:0]       opb_select;
    xlen_t [`EX_NUM_LANES-1:0]          rs1_val, rs2_val, pc, npc;
    inst_t [`EX_NUM_LANES-1:0]          inst;
    rob_tag_t [`EX_NUM_LANES-1:0]       rob_tag;
    lane_vec_t                          cond_branch, uncond_branch, mem_op;
    logic                               cdb_busy;
    logic                               cdb_valid, cdb_take_branch, addr_valid;
    rob_tag_t                           cdb_tag, addr_tag;
    xlen_t                              cdb_value, addr;
    lane_vec_t                          lane_busy;

    // data lines, fields in file order
    logic [31:0] fld [MAX_LINES][15];
    int num_lines;
    // scoreboard by tag
    logic [31:0] exp_value [32];
    logic        exp_take [32];
    logic        exp_mem [32];
    int          seen [32];
    int          order_of [32];
    int          seen_count;
    // same-cycle issue pairs, lane 0 then lane 1
    int pair_a[$];
    int pair_b[$];
    logic [31:0] lfsr_state;
    logic busy_on;
    logic busy_seen;
    int cycles;
    int cycle_limit;

    stage_ex dut (.*);

    always #2 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // galois lfsr, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic draw_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic read_testdata();
        int fd;
        int n;
        string line;
        logic [31:0] v [15];
        fd = $fopen("stage_ex_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open stage_ex_testdata.txt");
            $display("FAIL: see errors above");
            $fatal(1);
        end
        num_lines = 0;
        while (!$feof(fd) && num_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                        v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
            if (n == 15) begin
                for (int k = 0; k < 15; k++)
                    fld[num_lines][k] = v[k];
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    // put line k onto lane l
    task automatic drive_issue(input int l, input int k);
        alu_func[l]      <= alu_func_e'(fld[k][1][3:0]);
        opa_select[l]    <= opa_sel_e'(fld[k][2][1:0]);
        opb_select[l]    <= opb_sel_e'(fld[k][3][2:0]);
        rs1_val[l]       <= fld[k][4];
        rs2_val[l]       <= fld[k][5];
        pc[l]            <= fld[k][6];
        npc[l]           <= fld[k][7];
        inst[l]          <= fld[k][8];
        rob_tag[l]       <= fld[k][9][4:0];
        cond_branch[l]   <= fld[k][10][0];
        uncond_branch[l] <= fld[k][11][0];
        mem_op[l]        <= fld[k][12][0];
    endtask

    //////////////////////////////
    // monitor
    //////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (cdb_valid) begin
                // granted while cdb_busy was low
                check_value("cdb_valid after busy edge", {31'b0, busy_seen}, 32'h0);
                check_value("cdb tag is memory op", {31'b0, exp_mem[cdb_tag]}, 32'h0);
                check_value("cdb tag repeat", seen[cdb_tag], 0);
                check_value("cdb_value", cdb_value, exp_value[cdb_tag]);
                check_value("cdb_take_branch", {31'b0, cdb_take_branch},
                            {31'b0, exp_take[cdb_tag]});
                seen[cdb_tag]++;
                seen_count++;
                order_of[cdb_tag] = seen_count;
            end
            if (addr_valid) begin
                check_value("addr tag is not memory op", {31'b0, exp_mem[addr_tag]}, 32'h1);
                check_value("addr tag repeat", seen[addr_tag], 0);
                check_value("addr", addr, exp_value[addr_tag]);
                seen[addr_tag]++;
                seen_count++;
                order_of[addr_tag] = seen_count;
            end
            busy_seen = cdb_busy;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d tags completed",
                     cycles, seen_count, num_lines);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        int idx;
        int l;
        logic idle;
        logic bb;
        lane_vec_t sel;
        int slot [`EX_NUM_LANES];
        clk = 1'b0;
        rst = 1'b1;
        issue_valid = '0;
        alu_func = '0;
        opa_select = '0;
        opb_select = '0;
        rs1_val = '0;
        rs2_val = '0;
        pc = '0;
        npc = '0;
        inst = '0;
        rob_tag = '0;
        cond_branch = '0;
        uncond_branch = '0;
        mem_op = '0;
        cdb_busy = 1'b0;
        lfsr_state = 32'h964d38f8;
        busy_on = 1'b0;
        busy_seen = 1'b0;
        cycles = 0;
        cycle_limit = 0;
        seen_count = 0;
        for (int t = 0; t < 32; t++) begin
            seen[t] = 0;
            order_of[t] = 0;
            exp_mem[t] = 1'b0;
        end
        read_testdata();
        cycle_limit = 40 * num_lines;
        for (int k = 0; k < num_lines; k++) begin
            exp_value[fld[k][9][4:0]] = fld[k][13];
            exp_take[fld[k][9][4:0]]  = fld[k][14][0];
            exp_mem[fld[k][9][4:0]]   = fld[k][12][0];
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // quiet after reset
        check_value("cdb_valid after reset", {31'b0, cdb_valid}, 32'h0);
        check_value("addr_valid after reset", {31'b0, addr_valid}, 32'h0);
        check_value("lane_busy after reset", {30'b0, lane_busy}, 32'h0);
        idx = 0;
        while (idx < num_lines || seen_count < num_lines) begin
            @(negedge clk);
            draw_bit(idle);
            draw_bit(bb);
            sel = '0;
            // up to one line per lane, in file order
            if (!idle) begin
                for (int k = 0; k < `EX_NUM_LANES; k++) begin
                    if (idx < num_lines) begin
                        l = fld[idx][0];
                        if (!lane_busy[l] && !issue_valid[l] && !sel[l]) begin
                            sel[l] = 1'b1;
                            slot[l] = idx;
                            idx++;
                        end
                    end
                end
            end
            if (idx >= BUSY_FROM)
                busy_on = 1'b1;
            @(posedge clk);
            issue_valid <= sel;
            cdb_busy <= busy_on & bb;
            for (int k = 0; k < `EX_NUM_LANES; k++)
                if (sel[k])
                    drive_issue(k, slot[k]);
            if (sel == 2'b11 && !fld[slot[0]][12][0] && !fld[slot[1]][12][0]) begin
                pair_a.push_back(fld[slot[0]][9]);
                pair_b.push_back(fld[slot[1]][9]);
            end
        end
        repeat (3) @(posedge clk);
        // every tag of the file completed exactly once
        for (int k = 0; k < num_lines; k++)
            check_value("tag completions", seen[fld[k][9][4:0]], 1);
        // lane 0 drains first
        foreach (pair_a[p])
            check_value("lane 0 before lane 1",
                        {31'b0, order_of[pair_a[p]] < order_of[pair_b[p]]}, 32'h1);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* stage_ex_testdata.txt */
# lane func opa opb rs1 rs2 pc npc inst tag cond uncond mem exp_value exp_take (all hex)
# opa 0 rs1 1 npc 2 pc 3 zero, opb 0 rs2 1 i 2 s 3 b 4 u 5 j
0 0 0 0 00000005 00000003 00000000 00000004 00000033 00 0 0 0 00000008 0
1 0 0 0 7fffffff 00000001 00000000 00000004 00000033 01 0 0 0 80000000 0
0 1 0 0 00000005 00000008 00000000 00000004 00000033 02 0 0 0 fffffffd 0
1 2 0 0 f0f0f0f0 ff00ff00 00000000 00000004 00000033 03 0 0 0 f000f000 0
0 3 0 0 f0f0f0f0 0f0f0000 00000000 00000004 00000033 04 0 0 0 fffff0f0 0
1 4 0 0 aaaa5555 ffff0000 00000000 00000004 00000033 05 0 0 0 55555555 0
0 5 0 0 ffffffff 00000001 00000000 00000004 00000033 06 0 0 0 00000001 0
1 6 0 0 ffffffff 00000001 00000000 00000004 00000033 07 0 0 0 00000000 0
0 7 0 0 00000001 00000024 00000000 00000004 00000033 08 0 0 0 00000010 0
1 8 0 0 80000000 00000004 00000000 00000004 00000033 09 0 0 0 08000000 0
0 9 0 0 80000000 00000004 00000000 00000004 00000033 0a 0 0 0 f8000000 0
1 0 0 1 00000010 00000000 00000000 00000004 00500013 0b 0 0 0 00000015 0
0 0 0 1 00000000 00000000 00000000 00000004 fff00013 0c 0 0 0 ffffffff 0
1 0 3 4 00000000 00000000 00000000 00000004 12345037 0d 0 0 0 12345000 0
0 0 2 4 00000000 00000000 00001000 00001004 12345017 0e 0 0 0 12346000 0
1 0 1 1 00000000 00000000 00001000 00001004 00500013 0f 0 0 0 00001009 0
0 0 2 5 00000000 00000000 00002000 00002004 0100006f 10 0 1 0 00002010 1
1 0 0 1 00003001 00000000 00002100 00002104 00500067 11 0 1 0 00003006 1
0 0 2 3 00000005 00000005 00004000 00004004 00208463 12 1 0 0 00004008 1
1 0 2 3 00000005 00000005 00004100 00004104 00209463 13 1 0 0 00004104 0
0 0 2 3 ffffffff 00000001 00005000 00005004 0020c463 14 1 0 0 00005008 1
1 0 2 3 ffffffff 00000001 00005100 00005104 0020d463 15 1 0 0 00005104 0
0 0 2 3 ffffffff 00000001 00006000 00006004 0020e463 16 1 0 0 00006004 0
1 0 2 3 ffffffff 00000001 00006100 00006104 0020f463 17 1 0 0 00006108 1
0 0 0 1 00008000 00000000 00000000 00000004 00502003 18 0 0 1 00008005 0
1 0 0 2 00009000 00000000 00000000 00000004 00a12423 19 0 0 1 00009008 0
0 0 0 0 00000001 00000002 00000000 00000004 00000033 1a 0 0 0 00000003 0
1 1 0 0 00000010 00000001 00000000 00000004 00000033 1b 0 0 0 0000000f 0
0 0 0 1 0000a000 00000000 00000000 00000004 00502003 1c 0 0 1 0000a005 0
1 4 0 0 0000ffff ffffffff 00000000 00000004 00000033 1d 0 0 0 ffff0000 0
0 7 0 0 00000003 0000001f 00000000 00000004 00000033 1e 0 0 0 80000000 0
1 0 0 2 0000b000 00000000 00000000 00000004 00a12423 1f 0 0 1 0000b008 0

/* src.f */
+incdir+.
ex_pkg.sv
alu.sv
branch_cond.sv
ex_lane.sv
completion_arbiter.sv
stage_ex.sv
tb_stage_ex.sv
